// ==== Makefile ====
TOP = tb_tcb_sys

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f tcb_sys.f
	out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "TB PASSED"

clean:
	rm -rf obj_dir

// ==== tb_tcb_sys.sv ====
// self-checking testbench for the two-manager bus system, built from the file list and run under Verilator
`timescale 1ns/1ns
`include "tcb_consts.svh"

module tb_tcb_sys
  import tcb_pkg::*;
();

  ////////////////////////////////////////
  // stimulus types and limits
  ////////////////////////////////////////

  // cycles a manager may wait for ready
  localparam int TIMEOUT = 8;
  // byte offset bits and word index bits
  localparam int OL = $clog2(`TCB_BW);
  localparam int WL = $clog2(`TCB_DEPTH);

  // one manager request
  typedef struct packed {
    logic     vld;
    logic     wen;
    tcb_adr_t adr;
    tcb_ben_t ben;
    tcb_dat_t wdt;
  } req_t;

  // one table row, rnd lets idle slots pick up a random read
  typedef struct packed {
    int   tst;
    req_t r0;
    req_t r1;
    logic rnd;
  } step_t;

  logic                   clk;
  logic                   rst;
  logic     [`TCB_PN-1:0] m_vld;
  logic     [`TCB_PN-1:0] m_wen;
  tcb_adr_t [`TCB_PN-1:0] m_adr;
  tcb_ben_t [`TCB_PN-1:0] m_ben;
  tcb_dat_t [`TCB_PN-1:0] m_wdt;
  logic     [`TCB_PN-1:0] m_rdy;
  tcb_dat_t [`TCB_PN-1:0] m_rdt;

  // reference memory and expected responses
  tcb_dat_t               ref_mem [0:`TCB_DEPTH-1];
  logic     [`TCB_PN-1:0] pend_rd;
  tcb_dat_t [`TCB_PN-1:0] pend_dat;
  // managers still waiting for ready
  logic     [`TCB_PN-1:0] busy;

  step_t       steps [$];
  logic [15:0] lfsr;
  logic        timed_out;
  int          errs;
  int          test_errs;
  int          checks;
  int          xfers;
  int          ntests;
  int          cur;

  tcb_sys i_dut (
    .clk   (clk),
    .rst   (rst),
    .m_vld (m_vld),
    .m_wen (m_wen),
    .m_adr (m_adr),
    .m_ben (m_ben),
    .m_wdt (m_wdt),
    .m_rdy (m_rdy),
    .m_rdt (m_rdt)
  );

  always #50 clk = ~clk;

  ////////////////////////////////////////
  // helpers
  ////////////////////////////////////////

  function automatic req_t write_req(input tcb_adr_t adr, input tcb_ben_t ben,
                                     input tcb_dat_t wdt);
    return '{vld: 1'b1, wen: 1'b1, adr: adr, ben: ben, wdt: wdt};
  endfunction

  function automatic req_t read_req(input tcb_adr_t adr);
    return '{vld: 1'b1, wen: 1'b0, adr: adr, ben: '1, wdt: '0};
  endfunction

  function automatic req_t no_req();
    return '0;
  endfunction

  // word k of the scratch area used by the random run
  function automatic tcb_adr_t word_adr(input logic [2:0] k);
    return 12'h100 | {7'd0, k, 2'b00};
  endfunction

  // galois lfsr, one step per bit handed out
  function automatic logic rand_bit();
    logic b;
    b = lfsr[0];
    lfsr = lfsr >> 1;
    if (b) begin
      lfsr = lfsr ^ 16'hB400;
    end
    return b;
  endfunction

  function automatic tcb_adr_t rand_adr();
    logic [2:0] k;
    k[2] = rand_bit();
    k[1] = rand_bit();
    k[0] = rand_bit();
    return word_adr(k);
  endfunction

  // byte enables widened to a bit mask
  function automatic tcb_dat_t lane_mask(input tcb_ben_t ben);
    return {{8{ben[3]}}, {8{ben[2]}}, {8{ben[1]}}, {8{ben[0]}}};
  endfunction

  function automatic step_t idle_step();
    return '{tst: 0, r0: '0, r1: '0, rnd: 1'b0};
  endfunction

  function automatic string test_name(input int n);
    case (n)
      1: return "single manager write and read";
      2: return "priority under contention";
      3: return "response routing";
      4: return "read after write";
      5: return "random contention";
      default: return "reset state";
    endcase
  endfunction

  task add_step(input int tst, input req_t r0, input req_t r1, input logic rnd);
    steps.push_back('{tst: tst, r0: r0, r1: r1, rnd: rnd});
  endtask

  task count_error();
    errs++;
    test_errs++;
  endtask

  task report_test(input int n);
    $display("test %0d %s: %0d errors", n, test_name(n), test_errs);
    ntests++;
    test_errs = 0;
  endtask

  ////////////////////////////////////////
  // per-cycle checking at the falling edge
  ////////////////////////////////////////

  // read data owed from the previous cycle, zero if none
  task check_rdt(input tcb_sel_t mi);
    tcb_dat_t want;
    want = pend_rd[mi] ? pend_dat[mi] : '0;
    checks++;
    if (m_rdt[mi] !== want) begin
      $display("ERR m_rdt[%0d] exp %h got %h", mi, want, m_rdt[mi]);
      count_error();
    end
  endtask

  // handshake of this cycle into the reference model
  task record_xfer(input tcb_sel_t mi);
    logic [WL-1:0] widx;
    tcb_dat_t      mask;
    pend_rd[mi] = 1'b0;
    if (m_vld[mi] && m_rdy[mi]) begin
      widx = m_adr[mi][`TCB_AW-1:OL];
      xfers++;
      busy[mi] = 1'b0;
      if (m_wen[mi]) begin
        mask = lane_mask(m_ben[mi]);
        ref_mem[widx] = (ref_mem[widx] & ~mask) | (m_wdt[mi] & mask);
      end else begin
        pend_rd[mi] = 1'b1;
        pend_dat[mi] = ref_mem[widx];
      end
    end
  endtask

  task sample_cycle();
    logic [`TCB_PN-1:0] rdy_exp;
    // manager 1 outranks manager 0
    rdy_exp[1] = m_vld[1];
    rdy_exp[0] = m_vld[0] & ~m_vld[1];
    check_rdt(1'b0);
    check_rdt(1'b1);
    checks++;
    if (m_rdy !== rdy_exp) begin
      $display("ERR m_rdy exp %h got %h", rdy_exp, m_rdy);
      count_error();
    end
    record_xfer(1'b0);
    record_xfer(1'b1);
  endtask

  ////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////

  task drive_pair(input req_t r0, input req_t r1);
    m_vld <= {r1.vld, r0.vld};
    m_wen <= {r1.wen, r0.wen};
    m_adr <= {r1.adr, r0.adr};
    m_ben <= {r1.ben, r0.ben};
    m_wdt <= {r1.wdt, r0.wdt};
    busy = {r1.vld, r0.vld};
  endtask

  // drive one row, hold waiting requests until ready or timeout
  task run_step(input step_t st);
    req_t r0;
    req_t r1;
    int   cnt;
    r0 = st.r0;
    r1 = st.r1;
    if (st.rnd && !r0.vld && rand_bit()) begin
      r0 = read_req(rand_adr());
    end
    if (st.rnd && !r1.vld && rand_bit()) begin
      r1 = read_req(rand_adr());
    end
    @(posedge clk);
    drive_pair(r0, r1);
    cnt = 0;
    do begin
      @(negedge clk);
      sample_cycle();
      cnt++;
      if (busy != '0 && cnt >= TIMEOUT) begin
        $display("timeout: manager mask %b got no ready within %0d cycles", busy, TIMEOUT);
        timed_out = 1'b1;
      end else if (busy != '0) begin
        @(posedge clk);
        // finished managers go idle, the rest hold
        m_vld <= m_vld & busy;
      end
    end while (busy != '0 && !timed_out);
  endtask

  task load_table();
    tcb_adr_t a;
    tcb_dat_t d;
    tcb_ben_t b;
    add_step(1, write_req(12'h010, 4'hF, 32'h11223344), no_req(), 1'b0);
    add_step(1, read_req(12'h010), no_req(), 1'b0);
    add_step(1, write_req(12'h010, 4'h5, 32'hAABBCCDD), no_req(), 1'b0);
    add_step(1, read_req(12'h010), no_req(), 1'b0);
    add_step(1, no_req(), write_req(12'h020, 4'hF, 32'h01020304), 1'b0);
    add_step(1, no_req(), write_req(12'h020, 4'hC, 32'hDEADBEEF), 1'b0);
    add_step(1, no_req(), read_req(12'h020), 1'b0);
    // same-cycle requests, manager 0 must wait
    add_step(2, write_req(12'h030, 4'hF, 32'h30303030),
             write_req(12'h034, 4'hF, 32'h34343434), 1'b0);
    add_step(2, read_req(12'h034), read_req(12'h030), 1'b0);
    add_step(2, write_req(12'h040, 4'hF, 32'h0000AAAA),
             write_req(12'h040, 4'hF, 32'hBBBB0000), 1'b0);
    add_step(2, read_req(12'h040), no_req(), 1'b0);
    // alternating owners, one read per cycle
    add_step(3, read_req(12'h010), no_req(), 1'b0);
    add_step(3, no_req(), read_req(12'h020), 1'b0);
    add_step(3, read_req(12'h030), no_req(), 1'b0);
    add_step(3, no_req(), read_req(12'h034), 1'b0);
    add_step(3, read_req(12'h040), no_req(), 1'b0);
    add_step(4, no_req(), write_req(12'h050, 4'hF, 32'h55667788), 1'b0);
    add_step(4, read_req(12'h050), no_req(), 1'b0);
    add_step(4, read_req(12'h050), write_req(12'h050, 4'hF, 32'h99AABBCC), 1'b0);
    add_step(4, write_req(12'h054, 4'hF, 32'h0BADF00D), no_req(), 1'b0);
    add_step(4, no_req(), read_req(12'h054), 1'b0);
    // prefill the scratch words so random reads never see unknown data
    for (int k = 0; k < 8; k++) begin
      a = word_adr(3'(k));
      d = {24'hC0DE00, 8'(k)};
      if (k % 2 == 1) begin
        add_step(5, no_req(), write_req(a, 4'hF, d), 1'b0);
      end else begin
        add_step(5, write_req(a, 4'hF, d), no_req(), 1'b0);
      end
    end
    for (int k = 0; k < 24; k++) begin
      a = word_adr(3'(k * 3));
      d = {8'(k), 8'hA5, 8'(k * 7), 8'h3C};
      b = 4'(k + 1);
      case (k % 3)
        0: add_step(5, no_req(), write_req(a, b, d), 1'b1);
        1: add_step(5, write_req(a, b, d), no_req(), 1'b1);
        default: add_step(5, no_req(), no_req(), 1'b1);
      endcase
    end
    for (int k = 0; k < 4; k++) begin
      add_step(5, read_req(word_adr(3'(k))), read_req(word_adr(3'(k + 4))), 1'b0);
    end
  endtask

  ////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////

  initial begin
    clk = 1'b0;
    rst = 1'b1;
    m_vld = '0;
    m_wen = '0;
    m_adr = '0;
    m_ben = '0;
    m_wdt = '0;
    pend_rd = '0;
    pend_dat = '0;
    busy = '0;
    lfsr = 16'd63047;
    timed_out = 1'b0;
    errs = 0;
    test_errs = 0;
    checks = 0;
    xfers = 0;
    ntests = 0;
    load_table();
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    // idle bus after reset, nothing outstanding
    for (int c = 0; c < 3; c++) begin
      @(negedge clk);
      sample_cycle();
    end
    report_test(6);
    cur = steps[0].tst;
    for (int s = 0; s < steps.size() && !timed_out; s++) begin
      if (steps[s].tst != cur) begin
        // drain the last response before the next test
        run_step(idle_step());
        report_test(cur);
        cur = steps[s].tst;
      end
      run_step(steps[s]);
    end
    if (!timed_out) begin
      run_step(idle_step());
    end
    report_test(cur);
    $display("tests %0d checks %0d transfers %0d errors %0d", ntests, checks, xfers, errs);
    if (errs == 0 && !timed_out) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// ==== tcb_consts.svh ====
// bus sizing and manager priority constants, included by every design file that needs them
`ifndef TCB_CONSTS_SVH
`define TCB_CONSTS_SVH

////////////////////////////////////////
// data path
////////////////////////////////////////

// data word width in bits
`define TCB_DW 32
// byte address width
`define TCB_AW 12
// byte lanes per word
`define TCB_BW 4
// memory size in words
`define TCB_DEPTH 1024

////////////////////////////////////////
// managers
////////////////////////////////////////

// number of managers on the bus
`define TCB_PN 2
// select index width
`define TCB_PL 1
// priority list, entry 0 wins, so manager 1 goes first
`define TCB_PRI '{1'd1, 1'd0}

`endif

// ==== tcb_lib_arbiter.sv ====
// fixed-priority arbiter that picks the manager index the multiplexer steers to the memory
`timescale 1ns/1ns
`include "tcb_consts.svh"

module tcb_lib_arbiter
  import tcb_pkg::*;
(
  // only sampled by the checks below
  input  logic              clk,
  input  logic              rst,
  // request valid per manager
  input  logic [`TCB_PN-1:0] vld,
  // winning manager
  output tcb_sel_t          sel
);

  ////////////////////////////////////////
  // priority table
  ////////////////////////////////////////

  // entry 0 holds the highest priority manager
  localparam tcb_sel_t PRI [0:`TCB_PN-1] = `TCB_PRI;

  // valid bits in priority order
  logic [`TCB_PN-1:0] vld_ord;
  // position of the winner in the priority list
  tcb_sel_t pos;

  ////////////////////////////////////////
  // reorder and encode
  ////////////////////////////////////////

  // bit i of the result is the valid of priority entry i
  function automatic logic [`TCB_PN-1:0] reorder(input logic [`TCB_PN-1:0] val);
    logic [`TCB_PN-1:0] res;
    for (int i = 0; i < `TCB_PN; i++) begin
      res[i] = val[PRI[i]];
    end
    return res;
  endfunction

  // lowest set bit wins
  // no bit set gives position 0
  function automatic tcb_sel_t encode(input logic [`TCB_PN-1:0] val);
    tcb_sel_t res;
    res = '0;
    // walk down so the lowest index is written last
    for (int i = `TCB_PN-1; i >= 0; i--) begin
      if (val[i]) begin
        res = tcb_sel_t'(i);
      end
    end
    return res;
  endfunction

  assign vld_ord = reorder(vld);
  assign pos     = encode(vld_ord);

  // map the list position back to a manager number
  assign sel = PRI[pos];

  ////////////////////////////////////////
  // checks
  ////////////////////////////////////////

  // the grant always lands on a manager that is asking
  a_sel_requests: assert property (@(posedge clk) disable iff (rst)
    (|vld) |-> vld[sel]);

  // the top entry of the priority list wins whenever it asks
  a_sel_top: assert property (@(posedge clk) disable iff (rst)
    vld[PRI[0]] |-> (sel == PRI[0]));

endmodule

// ==== tcb_lib_multiplexer.sv ====
// manager to subordinate multiplexer with built-in arbiter and one-cycle read response routing
`timescale 1ns/1ns
`include "tcb_consts.svh"

module tcb_lib_multiplexer
  import tcb_pkg::*;
(
  input  logic                      clk,
  input  logic                      rst,
  // manager side requests
  input  logic     [`TCB_PN-1:0]    m_vld,
  input  logic     [`TCB_PN-1:0]    m_wen,
  input  tcb_adr_t [`TCB_PN-1:0]    m_adr,
  input  tcb_ben_t [`TCB_PN-1:0]    m_ben,
  input  tcb_dat_t [`TCB_PN-1:0]    m_wdt,
  // manager side responses
  output logic     [`TCB_PN-1:0]    m_rdy,
  output tcb_dat_t [`TCB_PN-1:0]    m_rdt,
  // subordinate side request
  output logic                      s_vld,
  output logic                      s_wen,
  output tcb_adr_t                  s_adr,
  output tcb_ben_t                  s_ben,
  output tcb_dat_t                  s_wdt,
  // subordinate side read data, one cycle after the request
  input  tcb_dat_t                  s_rdt
);

  // current grant
  tcb_sel_t sel;
  // owner of the transfer in the previous cycle
  tcb_sel_t rd_own;
  // previous cycle was a read transfer
  logic     rd_flg;

  ////////////////////////////////////////
  // arbitration
  ////////////////////////////////////////

  tcb_lib_arbiter i_arb (
    .clk (clk),
    .rst (rst),
    .vld (m_vld),
    .sel (sel)
  );

  ////////////////////////////////////////
  // request path
  ////////////////////////////////////////

  // memory never stalls, so any valid is a transfer
  assign s_vld = |m_vld;

  // steer the winner's fields
  assign s_wen = m_wen[sel];
  assign s_adr = m_adr[sel];
  assign s_ben = m_ben[sel];
  assign s_wdt = m_wdt[sel];

  ////////////////////////////////////////
  // response path
  ////////////////////////////////////////

  // remember who read for the response next cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_flg <= 1'b0;
      rd_own <= '0;
    end else begin
      rd_flg <= s_vld & ~s_wen;
      if (s_vld && !s_wen) begin
        rd_own <= sel;
      end
    end
  end

  // ready to the winner only
  // read data to the owner only and zero elsewhere
  always_comb begin
    for (int i = 0; i < `TCB_PN; i++) begin
      m_rdy[i] = m_vld[i] && (sel == tcb_sel_t'(i));
      m_rdt[i] = (rd_flg && (rd_own == tcb_sel_t'(i))) ? s_rdt : '0;
    end
  end

  ////////////////////////////////////////
  // checks
  ////////////////////////////////////////

  // any request on the bus gets exactly one grant
  a_rdy_grant: assert property (@(posedge clk) disable iff (rst)
    s_vld |-> $onehot(m_rdy));

endmodule

// ==== tcb_mem.sv ====
// synchronous word memory subordinate with byte-enable writes and read data one cycle later
`timescale 1ns/1ns
`include "tcb_consts.svh"

module tcb_mem
  import tcb_pkg::*;
(
  input  logic     clk,
  // request from the multiplexer
  input  logic     vld,
  input  logic     wen,
  input  tcb_adr_t adr,
  input  tcb_ben_t ben,
  input  tcb_dat_t wdt,
  // read data, valid the cycle after a read
  output tcb_dat_t rdt
);

  ////////////////////////////////////////
  // address split
  ////////////////////////////////////////

  // byte offset bits inside a word
  localparam int unsigned OL = $clog2(`TCB_BW);
  // word index bits
  localparam int unsigned WL = $clog2(`TCB_DEPTH);

  // word index taken above the byte offset
  logic [WL-1:0] idx;

  assign idx = adr[OL +: WL];

  ////////////////////////////////////////
  // storage
  ////////////////////////////////////////

  tcb_dat_t mem [0:`TCB_DEPTH-1];

  // write enabled lanes at the transfer edge
  always_ff @(posedge clk) begin
    if (vld && wen) begin
      for (int b = 0; b < `TCB_BW; b++) begin
        if (ben[b]) begin
          mem[idx][8*b +: 8] <= wdt[8*b +: 8];
        end
      end
    end
  end

  ////////////////////////////////////////
  // read port
  ////////////////////////////////////////

  // old word is registered on a read
  // rdt holds between reads, the multiplexer masks it
  always_ff @(posedge clk) begin
    if (vld && !wen) begin
      rdt <= mem[idx];
    end
  end

  ////////////////////////////////////////
  // checks
  ////////////////////////////////////////

  // a request must carry a known address
  a_adr_known: assert property (@(posedge clk)
    vld |-> !$isunknown(adr));

endmodule

// ==== tcb_pkg.sv ====
// bus field types shared by the design and the testbench, imported with a wildcard
`include "tcb_consts.svh"

package tcb_pkg;

  ////////////////////////////////////////
  // request fields
  ////////////////////////////////////////

  // byte address
  typedef logic [`TCB_AW-1:0] tcb_adr_t;

  // read or write data word
  typedef logic [`TCB_DW-1:0] tcb_dat_t;

  // one enable per byte lane
  typedef logic [`TCB_BW-1:0] tcb_ben_t;

  ////////////////////////////////////////
  // interconnect control
  ////////////////////////////////////////

  // manager index
  // also the width of the arbiter select
  typedef logic [`TCB_PL-1:0] tcb_sel_t;

endpackage

// ==== tcb_sys.f ====
+incdir+.
tcb_pkg.sv
tcb_lib_arbiter.sv
tcb_lib_multiplexer.sv
tcb_mem.sv
tcb_sys.sv
tb_tcb_sys.sv

// ==== tcb_sys.sv ====
// top level joining the two bus managers to the shared memory through the multiplexer
`timescale 1ns/1ns
`include "tcb_consts.svh"

module tcb_sys
  import tcb_pkg::*;
(
  input  logic                      clk,
  input  logic                      rst,
  // manager requests
  input  logic     [`TCB_PN-1:0]    m_vld,
  input  logic     [`TCB_PN-1:0]    m_wen,
  input  tcb_adr_t [`TCB_PN-1:0]    m_adr,
  input  tcb_ben_t [`TCB_PN-1:0]    m_ben,
  input  tcb_dat_t [`TCB_PN-1:0]    m_wdt,
  // manager responses
  output logic     [`TCB_PN-1:0]    m_rdy,
  output tcb_dat_t [`TCB_PN-1:0]    m_rdt
);

  ////////////////////////////////////////
  // subordinate bus
  ////////////////////////////////////////

  logic     s_vld;
  logic     s_wen;
  tcb_adr_t s_adr;
  tcb_ben_t s_ben;
  tcb_dat_t s_wdt;
  tcb_dat_t s_rdt;

  // arbitration and response routing
  tcb_lib_multiplexer i_mux (
    .clk   (clk),
    .rst   (rst),
    .m_vld (m_vld),
    .m_wen (m_wen),
    .m_adr (m_adr),
    .m_ben (m_ben),
    .m_wdt (m_wdt),
    .m_rdy (m_rdy),
    .m_rdt (m_rdt),
    .s_vld (s_vld),
    .s_wen (s_wen),
    .s_adr (s_adr),
    .s_ben (s_ben),
    .s_wdt (s_wdt),
    .s_rdt (s_rdt)
  );

  // shared memory, always ready
  tcb_mem i_mem (
    .clk (clk),
    .vld (s_vld),
    .wen (s_wen),
    .adr (s_adr),
    .ben (s_ben),
    .wdt (s_wdt),
    .rdt (s_rdt)
  );

endmodule
